// File: hdl/alu_execute.sv
// single result slot; a new op is taken only after ack has been seen low again.
`timescale 1ns/1ps
`default_nettype none
`include "ooo_issue_params.svh"

module alu_execute (
	input wire issue_valid,
	input wire [issue_pkg::DISPATCH_W-1:0] issue_entry,
	output logic alu_idle,
	output logic res_req,
	output logic [issue_pkg::TAG_W-1:0] res_tag,
	output logic [issue_pkg::XLEN-1:0] res_data,
	input wire res_ack,
	input wire CLK,
	input wire reset
);

	import issue_pkg::*;

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_REQ  = 2'd1;
	localparam logic [1:0] S_DONE = 2'd2; // ack seen, waiting for it to drop.

	logic [1:0] state;
	logic [OP_W-1:0] opcode;
	logic [XLEN-1:0] src1;
	logic [XLEN-1:0] imm_ext;
	logic [XLEN-1:0] result;
	operand_word_t opnd;

	assign opcode  = issue_entry[OPC_LSB +: OP_W];
	assign src1    = issue_entry[SRC1_LSB +: XLEN];
	assign opnd    = issue_entry[OPND_LSB +: XLEN];
	assign imm_ext = {{(XLEN - 12){opnd.imm.simm[11]}}, opnd.imm.simm};

	always_comb begin
		case (opcode)
			`OP_ADD:  result = src1 + opnd.rs2;
			`OP_SUB:  result = src1 - opnd.rs2;
			`OP_AND:  result = src1 & opnd.rs2;
			`OP_OR:   result = src1 | opnd.rs2;
			`OP_XOR:  result = src1 ^ opnd.rs2;
			`OP_SLL:  result = src1 << opnd.rs2[3:0]; // low four bits only.
			`OP_ADDI: result = src1 + imm_ext;
			`OP_SLLI: result = src1 << opnd.imm.shamt;
			default:  result = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (issue_valid && state == S_IDLE) begin
			res_data <= result;
			res_tag  <= issue_entry[DTAG_LSB +: TAG_W];
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: if (issue_valid) state <= S_REQ;
				S_REQ:  if (res_ack) state <= S_DONE;
				S_DONE: if (!res_ack) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	assign alu_idle = (state == S_IDLE);
	assign res_req  = (state == S_REQ);

endmodule

`default_nettype wire

// File: hdl/free_slot_finder.sv
// returns the lowest clear bit of the valid vector; pos is meaningless while full is high.
`timescale 1ns/1ps
`default_nettype none
`include "ooo_issue_params.svh"

module free_slot_finder (
	input wire [`ISSUE_DEPTH-1:0] in,
	output logic [issue_pkg::IDX_W-1:0] pos,
	output logic full
);

	import issue_pkg::*;

	always_comb begin
		pos = '0;
		for (int i = DEPTH - 1; i >= 0; i--) begin
			if (!in[i]) begin
				pos = IDX_W'(i); // lower slots win.
			end
		end
	end

	assign full = &in;

endmodule

`default_nettype wire

// File: hdl/issue_buffer.sv
// DP must equal the params depth; a push while full is dropped even if a pop frees a slot.
`timescale 1ns/1ps
`default_nettype none
`include "ooo_issue_params.svh"

module issue_buffer #(
	parameter int DW = issue_pkg::DISPATCH_W,
	parameter int DP = `ISSUE_DEPTH
) (
	input wire [DW-1:0] dispat_info,
	input wire buffer_push,
	output logic buffer_full,

	input wire buffer_pop,
	input wire [$clog2(DP)-1:0] pop_index,
	output logic [DW*DP-1:0] issue_info_qout,
	output logic [DP-1:0] buffer_malloc_qout,
	output logic [$clog2(DP)-1:0] alloc_index,

	input wire CLK,
	input wire reset
);

	localparam int AW = $clog2(DP);

	logic [AW-1:0] free_index;
	logic push_ok;
	logic [DP-1:0] valid_next;

	free_slot_finder finder (
		.in(buffer_malloc_qout),
		.pos(free_index),
		.full(buffer_full)
	);

	assign push_ok = buffer_push & ~buffer_full;

	// a coinciding pop hands its slot straight to the new entry.
	assign alloc_index = (buffer_pop & buffer_push) ? pop_index : free_index;

	generate
		for (genvar dp = 0; dp < DP; dp++) begin : g_slot
			always_ff @(posedge CLK) begin
				if (push_ok && alloc_index == AW'(dp)) begin
					issue_info_qout[DW*dp +: DW] <= dispat_info;
				end
			end
		end
	endgenerate

	always_comb begin
		valid_next = buffer_malloc_qout;
		if (buffer_pop) begin
			valid_next[pop_index] = 1'b0;
		end
		if (push_ok) begin
			valid_next[alloc_index] = 1'b1; // set after clear, so a reused slot stays valid.
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			buffer_malloc_qout <= '0;
		end else begin
			buffer_malloc_qout <= valid_next;
		end
	end

endmodule

`default_nettype wire

// File: hdl/issue_config.sv
// issued count is read only and wraps; cfg_rdata is sampled when ack rises.
`timescale 1ns/1ps
`default_nettype none
`include "ooo_issue_params.svh"

module issue_config (
	input wire cfg_req,
	input wire cfg_write,
	input wire [1:0] cfg_addr,
	input wire [issue_pkg::XLEN-1:0] cfg_wdata,
	output logic cfg_ack,
	output logic [issue_pkg::XLEN-1:0] cfg_rdata,
	input wire buffer_pop,
	input wire [issue_pkg::DEPTH-1:0] buffer_malloc_qout,
	output logic issue_enable,
	output logic policy,
	input wire CLK,
	input wire reset
);

	import issue_pkg::*;

	logic [1:0] ctrl; // bit 1 policy, bit 0 enable.
	logic [XLEN-1:0] issued;
	logic [OCC_W-1:0] occupancy;
	logic start;

	assign start     = cfg_req & ~cfg_ack; // new access this cycle.
	assign occupancy = OCC_W'($countones(buffer_malloc_qout));

	always_ff @(posedge CLK) begin
		if (reset) begin
			cfg_ack <= 1'b0;
			ctrl    <= 2'b01;
			issued  <= '0;
		end else begin
			if (start) begin
				cfg_ack <= 1'b1;
			end else if (!cfg_req) begin
				cfg_ack <= 1'b0;
			end
			if (start && cfg_write && cfg_addr == `CFG_CTRL) begin
				ctrl <= cfg_wdata[1:0];
			end
			if (buffer_pop) begin
				issued <= issued + 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (start) begin
			case (cfg_addr)
				`CFG_CTRL:      cfg_rdata <= XLEN'(ctrl);
				`CFG_ISSUED:    cfg_rdata <= issued;
				`CFG_OCCUPANCY: cfg_rdata <= XLEN'(occupancy);
				default:        cfg_rdata <= '0;
			endcase
		end
	end

	assign issue_enable = ctrl[0];
	assign policy       = ctrl[1];

endmodule

`default_nettype wire

// File: hdl/issue_pkg.sv
// entry layout packs the destination tag at the top and the operand word at bit 0.
`default_nettype none
`include "ooo_issue_params.svh"

package issue_pkg;

	localparam int XLEN  = `XLEN;
	localparam int DEPTH = `ISSUE_DEPTH;
	localparam int TAG_W = `TAG_W;
	localparam int IDX_W = $clog2(`ISSUE_DEPTH);
	localparam int OCC_W = $clog2(`ISSUE_DEPTH + 1);
	localparam int OP_W  = 3;

	localparam int OPND_LSB   = 0;
	localparam int SRC1_LSB   = OPND_LSB + XLEN;
	localparam int TAG2_LSB   = SRC1_LSB + XLEN;
	localparam int WAIT2_BIT  = TAG2_LSB + TAG_W;
	localparam int TAG1_LSB   = WAIT2_BIT + 1;
	localparam int WAIT1_BIT  = TAG1_LSB + TAG_W;
	localparam int OPC_LSB    = WAIT1_BIT + 1;
	localparam int DTAG_LSB   = OPC_LSB + OP_W;
	localparam int DISPATCH_W = DTAG_LSB + TAG_W;

	localparam int WAITS_LSB = TAG2_LSB; // wait and tag fields of both sources.
	localparam int WAITS_W   = WAIT1_BIT - TAG2_LSB + 1;

	typedef union packed {
		logic [`XLEN-1:0] rs2; // register form.
		struct packed {
			logic [3:0]  shamt; // slli shift amount.
			logic [11:0] simm; // addi immediate, sign extended on use.
		} imm;
	} operand_word_t;

endpackage

`default_nettype wire

// File: hdl/issue_select.sv
// wakeups come only from the writeback port; one slot leaves per cycle.
`timescale 1ns/1ps
`default_nettype none

module issue_select (
	input wire buffer_push,
	input wire [issue_pkg::IDX_W-1:0] alloc_index,
	input wire [issue_pkg::WAITS_W-1:0] push_waits,
	input wire [issue_pkg::DEPTH-1:0] buffer_malloc_qout,
	input wire wb_valid,
	input wire [issue_pkg::TAG_W-1:0] wb_tag,
	input wire imm_form,
	input wire issue_enable,
	input wire policy,
	input wire alu_idle,
	output logic buffer_pop,
	output logic [issue_pkg::IDX_W-1:0] pop_index,
	input wire CLK,
	input wire reset
);

	import issue_pkg::*;

	logic [DEPTH-1:0] wait1;
	logic [DEPTH-1:0] wait2;
	logic [TAG_W-1:0] tag1 [DEPTH];
	logic [TAG_W-1:0] tag2 [DEPTH];
	logic [DEPTH-1:0] older [DEPTH]; // older[i][j] set when slot j entered before slot i.

	logic push_ok;
	logic p_wait1;
	logic p_wait2;
	logic [TAG_W-1:0] p_tag1;
	logic [TAG_W-1:0] p_tag2;
	logic new_wait1;
	logic new_wait2;
	logic [DEPTH-1:0] live;
	logic [DEPTH-1:0] ready;
	logic [DEPTH-1:0] oldest;
	logic [DEPTH-1:0] cand;

	assign push_ok = buffer_push & ~(&buffer_malloc_qout); // same rule as the buffer.

	assign p_wait1 = push_waits[WAITS_W-1];
	assign p_tag1  = push_waits[WAITS_W-2 -: TAG_W];
	assign p_wait2 = push_waits[TAG_W];
	assign p_tag2  = push_waits[TAG_W-1:0];

	// wakeup in the write cycle is folded in here.
	assign new_wait1 = p_wait1 & ~(wb_valid & (p_tag1 == wb_tag));
	assign new_wait2 = p_wait2 & ~imm_form & ~(wb_valid & (p_tag2 == wb_tag));

	assign live = buffer_malloc_qout & ~(DEPTH'(buffer_pop) << pop_index);

	always_ff @(posedge CLK) begin
		if (reset) begin
			wait1 <= '0;
			wait2 <= '0;
		end else begin
			for (int i = 0; i < DEPTH; i++) begin
				if (wb_valid && tag1[i] == wb_tag) wait1[i] <= 1'b0;
				if (wb_valid && tag2[i] == wb_tag) wait2[i] <= 1'b0;
			end
			if (push_ok) begin
				wait1[alloc_index] <= new_wait1;
				wait2[alloc_index] <= new_wait2;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (push_ok) begin
			tag1[alloc_index] <= p_tag1;
			tag2[alloc_index] <= p_tag2;
			for (int i = 0; i < DEPTH; i++) begin
				older[i][alloc_index] <= 1'b0; // newcomer is younger than everyone.
			end
			older[alloc_index] <= live & ~(DEPTH'(1) << alloc_index);
		end
	end

	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			ready[i] = buffer_malloc_qout[i] & ~wait1[i] & ~wait2[i];
		end
		for (int i = 0; i < DEPTH; i++) begin
			oldest[i] = ready[i] & ~(|(older[i] & ready)); // no ready slot ahead of it.
		end
	end

	assign cand = policy ? ready : oldest;

	always_comb begin
		pop_index = '0;
		for (int i = DEPTH - 1; i >= 0; i--) begin
			if (cand[i]) pop_index = IDX_W'(i);
		end
	end

	assign buffer_pop = issue_enable & alu_idle & (|ready);

endmodule

`default_nettype wire

// File: hdl/ooo_issue_params.svh
// shared widths, opcodes and register addresses; the buffer depth must stay a power of two.
`ifndef OOO_ISSUE_PARAMS_SVH
`define OOO_ISSUE_PARAMS_SVH

`define XLEN          16
`define ISSUE_DEPTH   8
`define TAG_W         4

`define OP_ADD        3'd0
`define OP_SUB        3'd1
`define OP_AND        3'd2
`define OP_OR         3'd3
`define OP_XOR        3'd4
`define OP_SLL        3'd5
`define OP_ADDI       3'd6
`define OP_SLLI       3'd7

`define CFG_CTRL      2'd0
`define CFG_ISSUED    2'd1
`define CFG_OCCUPANCY 2'd2

`endif

// File: hdl/ooo_issue_top.sv
// wakeups from the ALU itself are not looped back; the writeback port must supply them.
`timescale 1ns/1ps
`default_nettype none

module ooo_issue_top (
	input wire CLK,
	input wire reset,

	input wire [issue_pkg::DISPATCH_W-1:0] dispatch_info,
	input wire dispatch_push,
	output logic dispatch_full,

	input wire wb_valid,
	input wire [issue_pkg::TAG_W-1:0] wb_tag,

	output logic res_req,
	output logic [issue_pkg::TAG_W-1:0] res_tag,
	output logic [issue_pkg::XLEN-1:0] res_data,
	input wire res_ack,

	input wire cfg_req,
	input wire cfg_write,
	input wire [1:0] cfg_addr,
	input wire [issue_pkg::XLEN-1:0] cfg_wdata,
	output logic cfg_ack,
	output logic [issue_pkg::XLEN-1:0] cfg_rdata
);

	import issue_pkg::*;

	logic buffer_pop;
	logic [IDX_W-1:0] pop_index;
	logic [IDX_W-1:0] alloc_index;
	logic [DISPATCH_W*DEPTH-1:0] issue_info_qout;
	logic [DEPTH-1:0] buffer_malloc_qout;
	logic issue_enable;
	logic policy;
	logic alu_idle;

	issue_buffer #(
		.DW(DISPATCH_W),
		.DP(DEPTH)
	) buffer (
		.dispat_info(dispatch_info),
		.buffer_push(dispatch_push),
		.buffer_full(dispatch_full),
		.buffer_pop(buffer_pop),
		.pop_index(pop_index),
		.issue_info_qout(issue_info_qout),
		.buffer_malloc_qout(buffer_malloc_qout),
		.alloc_index(alloc_index),
		.CLK(CLK),
		.reset(reset)
	);

	issue_select select (
		.buffer_push(dispatch_push),
		.alloc_index(alloc_index),
		.push_waits(dispatch_info[WAITS_LSB +: WAITS_W]),
		.buffer_malloc_qout(buffer_malloc_qout),
		.wb_valid(wb_valid),
		.wb_tag(wb_tag),
		.imm_form(dispatch_info[OPC_LSB+2] & dispatch_info[OPC_LSB+1]), // addi and slli.
		.issue_enable(issue_enable),
		.policy(policy),
		.alu_idle(alu_idle),
		.buffer_pop(buffer_pop),
		.pop_index(pop_index),
		.CLK(CLK),
		.reset(reset)
	);

	alu_execute alu (
		.issue_valid(buffer_pop),
		.issue_entry(issue_info_qout[DISPATCH_W*pop_index +: DISPATCH_W]),
		.alu_idle(alu_idle),
		.res_req(res_req),
		.res_tag(res_tag),
		.res_data(res_data),
		.res_ack(res_ack),
		.CLK(CLK),
		.reset(reset)
	);

	issue_config config_regs (
		.cfg_req(cfg_req),
		.cfg_write(cfg_write),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_ack(cfg_ack),
		.cfg_rdata(cfg_rdata),
		.buffer_pop(buffer_pop),
		.buffer_malloc_qout(buffer_malloc_qout),
		.issue_enable(issue_enable),
		.policy(policy),
		.CLK(CLK),
		.reset(reset)
	);

endmodule

`default_nettype wire

// File: ooo_issue.f
+incdir+hdl
hdl/issue_pkg.sv
hdl/free_slot_finder.sv
hdl/issue_buffer.sv
hdl/issue_select.sv
hdl/alu_execute.sv
hdl/issue_config.sv
hdl/ooo_issue_top.sv
tests/ooo_issue_tb.sv

// File: tests/ooo_issue_tb.sv
// model tracks slots exactly only while pushes land with issue disabled; tags are never reused in flight.
`timescale 1ns/1ps
`default_nettype none
`include "ooo_issue_params.svh"

module ooo_issue_tb;

	import issue_pkg::*;

	localparam int MAX_CYCLES = 4000; // about four times the whole run.

	logic CLK;
	logic reset;
	logic [DISPATCH_W-1:0] dispatch_info;
	logic dispatch_push;
	logic dispatch_full;
	logic wb_valid;
	logic [TAG_W-1:0] wb_tag;
	logic res_req;
	logic [TAG_W-1:0] res_tag;
	logic [XLEN-1:0] res_data;
	logic res_ack;
	logic cfg_req;
	logic cfg_write;
	logic [1:0] cfg_addr;
	logic [XLEN-1:0] cfg_wdata;
	logic cfg_ack;
	logic [XLEN-1:0] cfg_rdata;

	int err_data = 0;
	int err_order = 0;
	int err_proto = 0;
	int err_cfg = 0;
	int cycles = 0;
	int results_seen = 0;
	logic [15:0] lfsr = 16'd47;

	// slot image of the buffer.
	logic [7:0] m_valid = '0;
	logic [7:0] m_wait = '0;
	logic [7:0] m_queued = '0; // already placed in the expected order.
	logic [3:0] m_tag [8];
	logic [3:0] m_wtag [8];
	int m_seq [8];
	int seq_count = 0;
	logic [3:0] next_tag = '0;
	logic [15:0] pending = '0;
	logic [15:0] exp_data [16];
	logic [3:0] exp_order [$];

	ooo_issue_top dut (.*);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	function automatic logic [15:0] next_bits(input int n);
		logic [15:0] val;
		logic fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]; // x^16 + x^14 + x^13 + x^11 + 1.
			lfsr = {lfsr[14:0], fb};
			val = {val[14:0], fb};
		end
		return val;
	endfunction

	function automatic logic [15:0] expected_result(input logic [2:0] op, input logic [15:0] a,
			input logic [15:0] b);
		case (op)
			`OP_ADD:  return a + b;
			`OP_SUB:  return a - b;
			`OP_AND:  return a & b;
			`OP_OR:   return a | b;
			`OP_XOR:  return a ^ b;
			`OP_SLL:  return a << b[3:0];
			`OP_ADDI: return a + {{4{b[11]}}, b[11:0]}; // 12-bit signed immediate.
			default:  return a << b[15:12]; // slli shift amount sits on top.
		endcase
	endfunction

	// drives one push and enters it in the slot image under the lowest-free rule.
	task automatic queue_op(input logic [2:0] op, input logic [1:0] wt, input logic [3:0] wtag,
			input logic [15:0] w_set);
		logic [DISPATCH_W-1:0] e;
		logic [15:0] s1;
		logic [15:0] w;
		logic imm;
		int slot;
		s1 = next_bits(16);
		w = next_bits(16) | w_set;
		imm = (op == `OP_ADDI) || (op == `OP_SLLI);
		e = '0;
		e[DTAG_LSB +: TAG_W] = next_tag;
		e[OPC_LSB +: OP_W] = op;
		e[WAIT1_BIT] = wt[0];
		e[TAG1_LSB +: TAG_W] = wtag;
		e[WAIT2_BIT] = wt[1];
		e[TAG2_LSB +: TAG_W] = wtag;
		e[SRC1_LSB +: XLEN] = s1;
		e[OPND_LSB +: XLEN] = w;
		dispatch_info <= e;
		dispatch_push <= 1'b1;
		slot = -1;
		for (int i = 7; i >= 0; i--) begin
			if (!m_valid[i]) slot = i;
		end
		if (slot >= 0) begin
			m_valid[slot] = 1'b1;
			m_wait[slot] = wt[0] | (wt[1] & !imm); // immediates have no second source.
			m_queued[slot] = 1'b0;
			m_tag[slot] = next_tag;
			m_wtag[slot] = wtag;
			m_seq[slot] = seq_count;
			seq_count++;
			pending[next_tag] = 1'b1;
			exp_data[next_tag] = expected_result(op, s1, w);
		end
		next_tag = next_tag + 4'd1;
	endtask

	task automatic wake_model(input logic [3:0] tag);
		for (int i = 0; i < 8; i++) begin
			if (m_valid[i] && m_wtag[i] == tag) m_wait[i] = 1'b0;
		end
	endtask

	// appends the ready, not yet ordered slots in issue order.
	task automatic predict_order(input logic pol);
		int best;
		for (int n = 0; n < 8; n++) begin
			best = -1;
			for (int i = 0; i < 8; i++) begin
				if (m_valid[i] && !m_wait[i] && !m_queued[i]) begin
					if (best < 0 || (!pol && m_seq[i] < m_seq[best])) best = i;
				end
			end
			if (best >= 0) begin
				m_queued[best] = 1'b1;
				exp_order.push_back(m_tag[best]);
			end
		end
	endtask

	task automatic take_result(input logic [3:0] tag, input logic [15:0] data);
		assert (pending[tag]) else begin
			err_order++;
			$display("result for tag %0d was not outstanding or came twice", tag);
		end
		assert (data == exp_data[tag]) else begin
			err_data++;
			$display("error %0t res_data expected %h got %h", $time, exp_data[tag], data);
		end
		assert (exp_order.size() > 0) else begin
			err_order++;
			$display("result with tag %0d arrived when none was expected", tag);
		end
		if (exp_order.size() > 0) begin
			assert (exp_order[0] == tag) else begin
				err_order++;
				$display("error %0t res_tag expected %0d got %0d", $time, exp_order[0], tag);
			end
			void'(exp_order.pop_front());
		end
		for (int i = 0; i < 8; i++) begin
			if (m_valid[i] && m_tag[i] == tag) m_valid[i] = 1'b0;
		end
		pending[tag] = 1'b0;
		results_seen++;
	endtask

	task automatic cfg_access(input logic wr, input logic [1:0] addr, input logic [15:0] wd,
			output logic [15:0] rd);
		@(posedge CLK);
		cfg_req <= 1'b1;
		cfg_write <= wr;
		cfg_addr <= addr;
		cfg_wdata <= wd;
		do begin
			@(posedge CLK);
		end while (!cfg_ack);
		rd = cfg_rdata; // valid while ack is high.
		cfg_req <= 1'b0;
		do begin
			@(posedge CLK);
		end while (cfg_ack);
	endtask

	task automatic check_reg(input logic [1:0] addr, input logic [15:0] expv, input string name);
		logic [15:0] rd;
		cfg_access(1'b0, addr, 16'd0, rd);
		assert (rd == expv) else begin
			err_cfg++;
			$display("error %0t %s expected %h got %h", $time, name, expv, rd);
		end
	endtask

	task automatic write_ctrl(input logic [15:0] v);
		logic [15:0] rd;
		cfg_access(1'b1, `CFG_CTRL, v, rd);
		check_reg(`CFG_CTRL, v, "cfg_rdata (ctrl)");
	endtask

	task automatic wait_for_results(input int target);
		while (results_seen < target) @(posedge CLK);
		repeat (4) @(posedge CLK);
	endtask

	// result consumer with a random ack delay.
	initial begin
		int delay;
		res_ack = 1'b0;
		forever begin
			@(posedge CLK);
			if (res_req && !reset) begin
				take_result(res_tag, res_data);
				delay = next_bits(3);
				repeat (delay) @(posedge CLK);
				res_ack <= 1'b1;
				do begin
					@(posedge CLK);
				end while (res_req);
				res_ack <= 1'b0;
			end
		end
	end

	assert property (@(posedge CLK) disable iff (reset)
		res_req && !res_ack |=> res_req && $stable(res_tag) && $stable(res_data))
	else begin
		err_proto++;
		$display("result port dropped or changed before res_ack at %0t", $time);
	end

	assert property (@(posedge CLK) disable iff (reset) res_ack |=> !res_req)
	else begin
		err_proto++;
		$display("new result raised while res_ack was still high at %0t", $time);
	end

	assert property (@(posedge CLK) disable iff (reset) $rose(cfg_ack) |-> $past(cfg_req))
	else begin
		err_proto++;
		$display("cfg_ack rose without a request at %0t", $time);
	end

	assert property (@(posedge CLK) disable iff (reset) $fell(cfg_ack) |-> !$past(cfg_req))
	else begin
		err_proto++;
		$display("cfg_ack fell while cfg_req was still high at %0t", $time);
	end

	initial begin
		int base;
		reset = 1'b1;
		dispatch_info = '0;
		dispatch_push = 1'b0;
		wb_valid = 1'b0;
		wb_tag = '0;
		cfg_req = 1'b0;
		cfg_write = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		repeat (10) @(posedge CLK);
		reset <= 1'b0;
		@(posedge CLK);
		assert (!dispatch_full && !res_req && !cfg_ack) else begin
			err_proto++;
			$display("outputs not idle after reset");
		end
		check_reg(`CFG_CTRL, 16'd1, "cfg_rdata (ctrl)");

		// an op waiting on tag 5 lets younger independent ops pass.
		base = results_seen;
		@(posedge CLK);
		queue_op(`OP_ADD, 1'b1, 4'd5, 16'h0);
		@(posedge CLK);
		queue_op(`OP_SUB, 1'b0, 4'd0, 16'h0);
		@(posedge CLK);
		queue_op(`OP_XOR, 1'b0, 4'd0, 16'h0);
		predict_order(1'b0);
		@(posedge CLK);
		dispatch_push <= 1'b0;
		wait_for_results(base + 2);
		@(posedge CLK);
		wb_valid <= 1'b1;
		wb_tag <= 4'd5;
		queue_op(`OP_OR, 2'b11, 4'd5, 16'h0); // woken in its own write cycle.
		wake_model(4'd5);
		predict_order(1'b0);
		@(posedge CLK);
		wb_valid <= 1'b0;
		dispatch_push <= 1'b0;
		wait_for_results(base + 4);

		// scrambled slots are drained once under each policy.
		for (int p = 0; p < 2; p++) begin
			base = results_seen;
			write_ctrl(16'd0);
			@(posedge CLK);
			queue_op(`OP_ADD, 1'b1, 4'd9, 16'h0);
			@(posedge CLK);
			queue_op(`OP_SUB, 1'b0, 4'd0, 16'h0);
			@(posedge CLK);
			queue_op(`OP_AND, 2'b10, 4'd9, 16'h0); // waits on its second source.
			@(posedge CLK);
			queue_op(`OP_SLLI, 2'b10, 4'd12, 16'h0); // second-source wait is ignored.
			@(posedge CLK);
			dispatch_push <= 1'b0;
			predict_order(1'b0);
			write_ctrl(16'd1);
			wait_for_results(base + 2); // slots 1 and 3 are now free.
			write_ctrl(16'd0);
			for (int k = 0; k < 3; k++) begin
				@(posedge CLK);
				queue_op(3'(k + 2), 1'b0, 4'd0, 16'h0);
			end
			@(posedge CLK);
			dispatch_push <= 1'b0;
			wb_valid <= 1'b1;
			wb_tag <= 4'd9;
			wake_model(4'd9);
			@(posedge CLK);
			wb_valid <= 1'b0;
			predict_order(p[0]);
			write_ctrl({14'd0, p[0], 1'b1});
			wait_for_results(base + 7);
		end

		// every opcode once fills the buffer and the ninth push is dropped.
		for (int round = 0; round < 2; round++) begin
			base = results_seen;
			write_ctrl(16'd0);
			for (int op = 0; op < 9; op++) begin
				@(posedge CLK);
				queue_op(3'(op), 1'b0, 4'd0, (round == 0 && op == 6) ? 16'h0800 : 16'h0);
			end
			@(posedge CLK);
			dispatch_push <= 1'b0;
			@(posedge CLK);
			assert (dispatch_full) else begin
				err_proto++;
				$display("dispatch_full stayed low with eight entries at %0t", $time);
			end
			check_reg(`CFG_OCCUPANCY, 16'd8, "cfg_rdata (occupancy)");
			predict_order(1'b0);
			write_ctrl(16'd1);
			wait_for_results(base + 8);
			repeat (20) @(posedge CLK);
			assert (results_seen == base + 8) else begin
				err_order++;
				$display("expected eight results from a full buffer, got %0d", results_seen - base);
			end
		end

		check_reg(`CFG_ISSUED, 16'(results_seen), "cfg_rdata (issued)");
		check_reg(`CFG_OCCUPANCY, 16'd0, "cfg_rdata (occupancy)");
		assert (pending == '0 && exp_order.size() == 0) else begin
			err_order++;
			$display("some dispatched ops never returned a result");
		end
		$display("errors: data %0d order %0d protocol %0d config %0d, results %0d",
			err_data, err_order, err_proto, err_cfg, results_seen);
		if (err_data + err_order + err_proto + err_cfg == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
